//--- logic/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // instruction bits 6:2
    localparam logic [4:0] op_load   = 5'b00000;
    localparam logic [4:0] op_imm    = 5'b00100;
    localparam logic [4:0] op_store  = 5'b01000;
    localparam logic [4:0] op_op     = 5'b01100;
    localparam logic [4:0] op_lui    = 5'b01101;
    localparam logic [4:0] op_branch = 5'b11000;
    localparam logic [4:0] op_jal    = 5'b11011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_word    = 3'b010; // lw / sw only

    // register write-back source
    localparam logic [1:0] wb_sel_alu = 2'd0;
    localparam logic [1:0] wb_sel_bus = 2'd1;
    localparam logic [1:0] wb_sel_imm = 2'd2;

    localparam word_t reset_vector = 32'h0000_0000;
    localparam word_t instr_len    = 32'd4;

endpackage

//--- logic/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  cpu_pkg::alu_op_e  op,
    input  cpu_pkg::word_t    a,
    input  cpu_pkg::word_t    b,
    output cpu_pkg::word_t    result,
    output logic              eq,
    output logic              busy
);

    cpu_pkg::word_t   comb_result;
    cpu_pkg::alu_op_e shift_op;
    logic [4:0]       shamt;
    logic             is_shift;

    assign is_shift = (op == cpu_pkg::alu_sll) || (op == cpu_pkg::alu_srl) ||
                      (op == cpu_pkg::alu_sra);

    always_comb begin
        case (op)
            cpu_pkg::alu_add:  comb_result = a + b;
            cpu_pkg::alu_sub:  comb_result = a - b;
            cpu_pkg::alu_slt:  comb_result = {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::alu_sltu: comb_result = {31'b0, a < b};
            cpu_pkg::alu_xor:  comb_result = a ^ b;
            cpu_pkg::alu_or:   comb_result = a | b;
            cpu_pkg::alu_and:  comb_result = a & b;
            default:           comb_result = a; // shifts start from a
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            shamt <= 5'd0;
        end else if (start) begin
            busy  <= is_shift && (b[4:0] != 5'd0);
            shamt <= b[4:0];
        end else if (busy) begin
            shamt <= shamt - 5'd1;
            busy  <= (shamt != 5'd1); // last bit this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result   <= comb_result;
            eq       <= (a == b);
            shift_op <= op;
        end else if (busy) begin
            // one position per cycle
            case (shift_op)
                cpu_pkg::alu_sll: result <= {result[30:0], 1'b0};
                cpu_pkg::alu_srl: result <= {1'b0, result[31:1]};
                cpu_pkg::alu_sra: result <= {result[31], result[31:1]};
                default:          result <= result;
            endcase
        end
    end

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               rd_we,
    input  cpu_pkg::word_t     rd_data,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data
);

    // x0 has no storage
    cpu_pkg::word_t regs [1:31];

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rd_we && (rd != 5'd0)) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

//--- logic/bus_wb8.sv
`timescale 1ns/1ns

module bus_wb8 (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           write,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wdata,
    output cpu_pkg::word_t rdata,
    output logic           busy,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::byte_t wb_dat_w,
    input  cpu_pkg::byte_t wb_dat_r,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    input  logic           wb_ack
);

    logic           active;
    logic [1:0]     cnt;     // bytes acked so far
    cpu_pkg::word_t wdata_q;
    logic           beat;

    // stb stays up between bytes, so cyc and stb move together
    assign wb_cyc   = active;
    assign wb_stb   = active;
    assign busy     = active;
    assign wb_dat_w = wdata_q[7:0];
    assign beat     = active && wb_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            cnt    <= 2'd0;
            wb_we  <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
            cnt    <= 2'd0;
            wb_we  <= write;
        end else if (beat) begin
            cnt <= cnt + 2'd1;
            if (cnt == 2'd3) begin
                active <= 1'b0;  // fourth ack ends the word
                wb_we  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr  <= addr;
            wdata_q <= wdata;
        end else if (beat) begin
            wb_adr  <= wb_adr + 32'd1;
            wdata_q <= {8'h00, wdata_q[31:8]}; // next byte up
            if (!wb_we) begin
                rdata <= {wb_dat_r, rdata[31:8]}; // low byte arrives first
            end
        end
    end

endmodule

//--- logic/control_fsm.sv
`timescale 1ns/1ns

module control_fsm (
    input  logic               clk,
    input  logic               reset,
    input  logic               alu_busy,
    input  logic               alu_eq,
    input  cpu_pkg::word_t     alu_result,
    input  cpu_pkg::word_t     bus_rdata,
    input  logic               bus_busy,
    output logic               alu_start,
    output logic               bus_start,
    output logic               bus_write,
    output logic               rd_we,
    output cpu_pkg::alu_op_e   alu_op,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::reg_addr_t rd,
    output cpu_pkg::word_t     imm,
    output cpu_pkg::word_t     pc,
    output logic               a_sel_pc,
    output logic               b_sel_imm,
    output logic               b_sel_len,
    output logic               addr_sel_pc,
    output logic [1:0]         wb_sel
);

    typedef enum logic [3:0] {
        st_fetch, st_decode, st_op,
        st_load_addr, st_load, st_store_addr, st_store,
        st_branch_cmp, st_branch_decide,
        st_jal_link, st_pc_next, st_pc_imm, st_pc_update
    } state_e;

    state_e           state, state_next;
    cpu_pkg::word_t   ir;
    logic             launched; // unit request already issued in this state
    logic             done;
    logic [4:0]       opcode;
    logic [2:0]       funct3;
    cpu_pkg::alu_op_e op_alu;

    assign opcode = ir[6:2];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign rd     = ir[11:7];

    always_comb begin
        case (opcode)
            cpu_pkg::op_store:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            cpu_pkg::op_branch: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            cpu_pkg::op_lui:    imm = {ir[31:12], 12'b0};
            cpu_pkg::op_jal:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:            imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    // sub only for register form, sra/srai both use bit 30
    always_comb begin
        case (funct3)
            cpu_pkg::f3_add_sub: op_alu = (opcode == cpu_pkg::op_op && ir[30]) ?
                                          cpu_pkg::alu_sub : cpu_pkg::alu_add;
            cpu_pkg::f3_sll:     op_alu = cpu_pkg::alu_sll;
            cpu_pkg::f3_slt:     op_alu = cpu_pkg::alu_slt;
            cpu_pkg::f3_sltu:    op_alu = cpu_pkg::alu_sltu;
            cpu_pkg::f3_xor:     op_alu = cpu_pkg::alu_xor;
            cpu_pkg::f3_srl_sra: op_alu = ir[30] ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
            cpu_pkg::f3_or:      op_alu = cpu_pkg::alu_or;
            default:             op_alu = cpu_pkg::alu_and;
        endcase
    end

    always_comb begin
        alu_start   = 1'b0;
        bus_start   = 1'b0;
        bus_write   = 1'b0;
        rd_we       = 1'b0;
        alu_op      = cpu_pkg::alu_add;
        a_sel_pc    = 1'b0;
        b_sel_imm   = 1'b0;
        b_sel_len   = 1'b0;
        addr_sel_pc = 1'b0;
        wb_sel      = cpu_pkg::wb_sel_alu;
        done        = 1'b1;
        state_next  = st_pc_next;
        case (state)
            st_fetch: begin
                bus_start   = !launched;
                addr_sel_pc = 1'b1;
                done        = launched && !bus_busy;
                state_next  = st_decode;
            end
            st_decode: begin
                case (opcode)
                    cpu_pkg::op_op, cpu_pkg::op_imm: state_next = st_op;
                    cpu_pkg::op_load:   if (funct3 == cpu_pkg::f3_word) state_next = st_load_addr;
                    cpu_pkg::op_store:  if (funct3 == cpu_pkg::f3_word) state_next = st_store_addr;
                    cpu_pkg::op_branch: state_next = st_branch_cmp;
                    cpu_pkg::op_jal:    state_next = st_jal_link;
                    cpu_pkg::op_lui: begin
                        rd_we  = 1'b1;
                        wb_sel = cpu_pkg::wb_sel_imm;
                    end
                    default: state_next = st_pc_next; // anything else is a no-op
                endcase
            end
            st_op: begin
                alu_start = !launched;
                alu_op    = op_alu;
                b_sel_imm = (opcode == cpu_pkg::op_imm);
                done      = launched && !alu_busy;
                rd_we     = done;
            end
            st_load_addr, st_store_addr: begin
                alu_start  = !launched;
                b_sel_imm  = 1'b1;
                done       = launched && !alu_busy;
                state_next = (state == st_load_addr) ? st_load : st_store;
            end
            st_load: begin
                bus_start = !launched;
                done      = launched && !bus_busy;
                rd_we     = done;
                wb_sel    = cpu_pkg::wb_sel_bus;
            end
            st_store: begin
                bus_start = !launched;
                bus_write = 1'b1;
                done      = launched && !bus_busy;
            end
            st_branch_cmp: begin
                alu_start  = !launched;
                alu_op     = cpu_pkg::alu_sub;
                done       = launched && !alu_busy;
                state_next = st_branch_decide;
            end
            st_branch_decide: begin
                if ((funct3 == cpu_pkg::f3_beq && alu_eq) ||
                    (funct3 == cpu_pkg::f3_bne && !alu_eq)) begin
                    state_next = st_pc_imm;
                end
            end
            st_jal_link: begin
                alu_start  = !launched;
                a_sel_pc   = 1'b1;
                b_sel_len  = 1'b1;
                done       = launched && !alu_busy;
                rd_we      = done; // link = pc + 4
                state_next = st_pc_imm;
            end
            st_pc_next, st_pc_imm: begin
                alu_start  = !launched;
                a_sel_pc   = 1'b1;
                b_sel_len  = (state == st_pc_next);
                b_sel_imm  = (state == st_pc_imm);
                done       = launched && !alu_busy;
                state_next = st_pc_update;
            end
            default: state_next = st_fetch; // pc update
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_fetch;
            launched <= 1'b0;
            pc       <= cpu_pkg::reset_vector;
        end else begin
            if (alu_start || bus_start) launched <= 1'b1;
            if (done) begin
                launched <= 1'b0;
                state    <= state_next;
            end
            if (state == st_pc_update) pc <= alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && done) begin
            ir <= bus_rdata;
        end
    end

endmodule

//--- logic/cpu.sv
`timescale 1ns/1ns

module cpu (
    input  logic           clk,
    input  logic           reset,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::byte_t wb_dat_w,
    input  cpu_pkg::byte_t wb_dat_r,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    input  logic           wb_ack
);

    logic               alu_start, alu_busy, alu_eq;
    logic               bus_start, bus_write, bus_busy;
    logic               rd_we;
    logic               a_sel_pc, b_sel_imm, b_sel_len, addr_sel_pc;
    logic [1:0]         wb_sel;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::reg_addr_t rs1, rs2, rd;
    cpu_pkg::word_t     imm, pc;
    cpu_pkg::word_t     alu_a, alu_b, alu_result;
    cpu_pkg::word_t     bus_addr, bus_rdata;
    cpu_pkg::word_t     rs1_data, rs2_data, rd_data;

    // operand and address muxes
    assign alu_a    = a_sel_pc ? pc : rs1_data;
    assign alu_b    = b_sel_len ? cpu_pkg::instr_len : (b_sel_imm ? imm : rs2_data);
    assign bus_addr = addr_sel_pc ? pc : alu_result;

    always_comb begin
        case (wb_sel)
            cpu_pkg::wb_sel_bus: rd_data = bus_rdata;
            cpu_pkg::wb_sel_imm: rd_data = imm; // lui
            default:             rd_data = alu_result;
        endcase
    end

    control_fsm u_ctrl (
        .clk(clk), .reset(reset),
        .alu_busy(alu_busy), .alu_eq(alu_eq), .alu_result(alu_result),
        .bus_rdata(bus_rdata), .bus_busy(bus_busy),
        .alu_start(alu_start), .bus_start(bus_start), .bus_write(bus_write),
        .rd_we(rd_we), .alu_op(alu_op),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .pc(pc),
        .a_sel_pc(a_sel_pc), .b_sel_imm(b_sel_imm), .b_sel_len(b_sel_len),
        .addr_sel_pc(addr_sel_pc), .wb_sel(wb_sel)
    );

    alu u_alu (
        .clk(clk), .reset(reset), .start(alu_start), .op(alu_op),
        .a(alu_a), .b(alu_b), .result(alu_result), .eq(alu_eq), .busy(alu_busy)
    );

    register_file u_regs (
        .clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .rd_we(rd_we),
        .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    bus_wb8 u_bus (
        .clk(clk), .reset(reset), .start(bus_start), .write(bus_write),
        .addr(bus_addr), .wdata(rs2_data), .rdata(bus_rdata), .busy(bus_busy),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_ack(wb_ack)
    );

endmodule

//--- verification/wb_memory.sv
`timescale 1ns/1ns

module wb_memory (
    input  logic           clk,
    input  logic           reset,
    input  logic           wait_en,
    input  cpu_pkg::word_t wb_adr,
    input  cpu_pkg::byte_t wb_dat_w,
    output cpu_pkg::byte_t wb_dat_r,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    output logic           wb_ack
);

    cpu_pkg::byte_t mem [0:1023];
    logic [31:0]    lfsr = 32'h28eac6e9;
    logic [31:0]    lfsr_next;
    logic           stalled;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign lfsr_next = lfsr_step(lfsr);
    assign wb_dat_r  = mem[wb_adr[9:0]];

    always @(posedge clk) begin
        if (reset) begin
            wb_ack  <= 1'b0;
            stalled <= 1'b0;
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (stalled) begin
                wb_ack  <= 1'b1;
                stalled <= 1'b0;
            end else if (wait_en) begin
                lfsr    <= lfsr_next; // one bit per byte
                stalled <= lfsr_next[0];
                wb_ack  <= !lfsr_next[0];
            end else begin
                wb_ack <= 1'b1;
            end
        end else begin
            wb_ack <= 1'b0;
        end
        if (wb_cyc && wb_stb && wb_we && wb_ack) begin
            mem[wb_adr[9:0]] <= wb_dat_w;
        end
    end

    task automatic clear();
        for (int i = 0; i < 1024; i++) mem[i] = 8'h00;
    endtask

    task automatic load_word(input int addr, input cpu_pkg::word_t w);
        for (int i = 0; i < 4; i++) mem[addr + i] = w[8*i +: 8];
    endtask

endmodule

//--- verification/cpu_chk.sv
`timescale 1ns/1ns

module cpu_chk (
    input logic           clk,
    input logic           reset,
    input cpu_pkg::word_t wb_adr,
    input cpu_pkg::byte_t wb_dat_w,
    input logic           wb_cyc,
    input logic           wb_stb,
    input logic           wb_we,
    input logic           wb_ack
);

    int fail_count = 0;

    // last acked byte of a word sits at offset 3
    word_ends_on_fourth_byte: assert property (@(posedge clk) disable iff (reset)
        $fell(wb_cyc) |-> ($past(wb_ack) && ($past(wb_adr[1:0]) == 2'b11)))
        else begin
            $error("cyc dropped before the fourth byte of a word");
            fail_count++;
        end

    // held until the acked edge
    hold_while_waiting: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
        else begin
            $error("bus signals moved before ack");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge clk) reset |=> !wb_cyc)
        else begin
            $error("cyc high after reset");
            fail_count++;
        end

endmodule

bind bus_wb8 cpu_chk chk_i (
    .clk(clk), .reset(reset), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_ack(wb_ack)
);

//--- verification/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

    localparam int max_cycles = 5 * 50 * 40; // tests x instructions x cycles

    logic clk = 1'b0;
    logic reset;
    logic wait_en;
    cpu_pkg::word_t wb_adr;
    cpu_pkg::byte_t wb_dat_w, wb_dat_r;
    logic wb_cyc, wb_stb, wb_we, wb_ack;

    int cycles = 0;
    int mismatches = 0;
    int other_errors = 0;
    int wr_index;
    logic end_seen;
    cpu_pkg::byte_t cap [0:1023];
    bit cap_valid [0:1023];
    cpu_pkg::word_t read_log [$];
    cpu_pkg::word_t prog [$];
    cpu_pkg::word_t exp_val [$];

    always #50 clk = ~clk;

    cpu uut (
        .clk(clk), .reset(reset), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_ack(wb_ack)
    );

    wb_memory mem_i (
        .clk(clk), .reset(reset), .wait_en(wait_en), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_cyc(wb_cyc),
        .wb_stb(wb_stb), .wb_we(wb_we), .wb_ack(wb_ack)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: program did not reach the end marker after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // bus monitor clears its record in reset
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 1024; i++) cap_valid[i] <= 1'b0;
            wr_index <= 0;
            end_seen <= 1'b0;
            read_log.delete();
        end else if (wb_cyc && wb_stb && wb_ack) begin
            if (wb_we) begin
                if (wb_adr[1:0] != 2'(wr_index)) begin
                    $display("write byte %0d of a word went to address %h", wr_index % 4, wb_adr);
                    other_errors++;
                end
                cap[wb_adr[9:0]]       <= wb_dat_w;
                cap_valid[wb_adr[9:0]] <= 1'b1;
                wr_index <= wr_index + 1;
                if (wb_adr[9:0] == 10'h3FF) end_seen <= 1'b1;
            end else if (read_log.size() < 4) begin
                read_log.push_back(wb_adr);
            end
        end
    end

    function automatic cpu_pkg::word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::op_op, 2'b11};
    endfunction

    function automatic cpu_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                             logic [4:0] rd, logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic cpu_pkg::word_t enc_sw(logic [11:0] imm, logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, cpu_pkg::f3_word, imm[4:0], cpu_pkg::op_store, 2'b11};
    endfunction

    function automatic cpu_pkg::word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::op_branch, 2'b11};
    endfunction

    function automatic cpu_pkg::word_t enc_jal(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::op_jal, 2'b11};
    endfunction

    function automatic cpu_pkg::word_t addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return enc_i(imm, rs1, cpu_pkg::f3_add_sub, rd, cpu_pkg::op_imm);
    endfunction

    task automatic check_word(input string name, input cpu_pkg::word_t expected,
                              input cpu_pkg::word_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_stored(input int addr, input cpu_pkg::word_t expected);
        cpu_pkg::word_t got;
        got = {cap[addr + 3], cap[addr + 2], cap[addr + 1], cap[addr]};
        check_bit($sformatf("stored flag %h", addr), 1'b1, cap_valid[addr]);
        check_word($sformatf("mem word %h", addr), expected, got);
    endtask

    task automatic check_absent(input int addr);
        if (cap_valid[addr]) begin
            $display("a store reached address %h on a path that should be skipped", addr);
            other_errors++;
        end
    endtask

    task automatic run_program();
        mem_i.clear();
        foreach (prog[i]) mem_i.load_word(4 * i, prog[i]);
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("wb_cyc", 1'b0, wb_cyc);
        check_bit("wb_stb", 1'b0, wb_stb);
        check_bit("wb_we", 1'b0, wb_we);
        while (!end_seen) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic add_case(input cpu_pkg::word_t instr, input cpu_pkg::word_t expected);
        prog.push_back(instr);
        prog.push_back(enc_sw(12'(32'h100 + 4 * exp_val.size()), 5'd10));
        exp_val.push_back(expected);
    endtask

    task automatic test_reset_fetch();
        prog.delete();
        prog.push_back(enc_sw(12'h3FC, 5'd0));
        run_program();
        check_word("read_log size", 32'd4, 32'(read_log.size()));
        for (int i = 0; i < read_log.size(); i++) check_word("fetch wb_adr", 32'(i), read_log[i]);
    endtask

    task automatic test_alu(input logic waits);
        prog.delete();
        exp_val.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'hFEC)); // x1 = -20
        prog.push_back(addi(5'd2, 5'd0, 12'd7));
        prog.push_back(addi(5'd3, 5'd0, 12'd3));
        add_case(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd10), 32'hFFFF_FFF3); // -13
        add_case(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd10), 32'hFFFF_FFE5); // -27
        add_case(enc_r(7'h00, 5'd3, 5'd1, 3'd1, 5'd10), 32'hFFFF_FF60); // -160
        add_case(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd10), 32'd1); // -20 < 7
        add_case(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd10), 32'd0); // huge unsigned
        add_case(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd10), 32'hFFFF_FFEB);
        add_case(enc_r(7'h00, 5'd3, 5'd1, 3'd5, 5'd10), 32'h1FFF_FFFD);
        add_case(enc_r(7'h20, 5'd3, 5'd1, 3'd5, 5'd10), 32'hFFFF_FFFD); // -3
        add_case(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd10), 32'hFFFF_FFEF);
        add_case(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd10), 32'h0000_0004);
        add_case(addi(5'd10, 5'd1, 12'd100), 32'd80);
        add_case(enc_i(12'd5, 5'd2, 3'd1, 5'd10, cpu_pkg::op_imm), 32'd224);
        add_case(enc_i(12'hFFB, 5'd1, 3'd2, 5'd10, cpu_pkg::op_imm), 32'd1); // -20 < -5
        add_case(enc_i(12'hFFF, 5'd2, 3'd3, 5'd10, cpu_pkg::op_imm), 32'd1); // 7 < 2^32-1
        add_case(enc_i(12'h0F0, 5'd1, 3'd4, 5'd10, cpu_pkg::op_imm), 32'hFFFF_FF1C);
        add_case(enc_i(12'd4, 5'd1, 3'd5, 5'd10, cpu_pkg::op_imm), 32'h0FFF_FFFE);
        add_case(enc_i(12'h404, 5'd1, 3'd5, 5'd10, cpu_pkg::op_imm), 32'hFFFF_FFFE); // -2
        add_case(enc_i(12'h300, 5'd2, 3'd6, 5'd10, cpu_pkg::op_imm), 32'h0000_0307);
        add_case(enc_i(12'h7F0, 5'd1, 3'd7, 5'd10, cpu_pkg::op_imm), 32'h0000_07E0);
        prog.push_back(enc_sw(12'h3FC, 5'd0));
        @(posedge clk);
        wait_en <= waits;
        run_program();
        foreach (exp_val[i]) check_stored(32'h100 + 4 * i, exp_val[i]);
        @(posedge clk);
        wait_en <= 1'b0;
    endtask

    task automatic test_lui_lw_sw();
        prog.delete();
        prog.push_back({20'h12345, 5'd5, cpu_pkg::op_lui, 2'b11});
        prog.push_back(addi(5'd5, 5'd5, 12'h678));
        prog.push_back(enc_sw(12'h200, 5'd5));
        prog.push_back(enc_i(12'h200, 5'd0, cpu_pkg::f3_word, 5'd6, cpu_pkg::op_load));
        prog.push_back(enc_sw(12'h204, 5'd6));
        prog.push_back(addi(5'd0, 5'd0, 12'd55)); // x0 stays zero
        prog.push_back(enc_sw(12'h208, 5'd0));
        prog.push_back(enc_sw(12'h3FC, 5'd0));
        run_program();
        check_stored(32'h200, 32'h1234_5678);
        check_stored(32'h204, 32'h1234_5678);
        check_stored(32'h208, 32'h0);
    endtask

    task automatic test_branch_jal();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));      // 0
        prog.push_back(addi(5'd2, 5'd0, 12'd5));      // 4
        prog.push_back(addi(5'd3, 5'd0, 12'd9));      // 8
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'd0)); // 12 beq taken
        prog.push_back(enc_sw(12'h300, 5'd3));        // 16 skipped
        prog.push_back(addi(5'd4, 5'd0, 12'h11));     // 20
        prog.push_back(enc_sw(12'h304, 5'd4));        // 24
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'd1)); // 28 bne not taken
        prog.push_back(enc_sw(12'h308, 5'd4));        // 32
        prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'd1)); // 36 bne taken
        prog.push_back(enc_sw(12'h30C, 5'd3));        // 40 skipped
        prog.push_back(enc_jal(21'd8, 5'd7));         // 44
        prog.push_back(enc_sw(12'h310, 5'd3));        // 48 skipped
        prog.push_back(enc_sw(12'h314, 5'd7));        // 52
        prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'd0)); // 56 beq not taken
        prog.push_back(enc_sw(12'h318, 5'd4));        // 60
        prog.push_back(enc_sw(12'h3FC, 5'd0));
        run_program();
        check_stored(32'h304, 32'h11);
        check_stored(32'h308, 32'h11);
        check_stored(32'h314, 32'd44 + 32'd4);
        check_stored(32'h318, 32'h11);
        check_absent(32'h300);
        check_absent(32'h30C);
        check_absent(32'h310);
    endtask

    task automatic test_unsupported();
        prog.delete();
        prog.push_back(addi(5'd8, 5'd0, 12'h55));
        prog.push_back(enc_sw(12'h100, 5'd8));
        prog.push_back({20'h00001, 5'd8, 5'b00101, 2'b11}); // auipc x8
        prog.push_back(32'h0000_000F);                       // fence
        prog.push_back(enc_sw(12'h104, 5'd8));
        prog.push_back(enc_sw(12'h3FC, 5'd0));
        run_program();
        check_stored(32'h100, 32'h55);
        check_stored(32'h104, 32'h55);
    endtask

    initial begin
        int assert_fails;
        reset   = 1'b1;
        wait_en = 1'b0;
        test_reset_fetch();
        test_alu(1'b0);
        test_lui_lw_sw();
        test_branch_jal();
        test_alu(1'b1);
        test_unsupported();
        assert_fails = uut.u_bus.chk_i.fail_count;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, other_errors, assert_fails);
        if (mismatches + other_errors + assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- files.f
logic/cpu_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/bus_wb8.sv
logic/control_fsm.sv
logic/cpu.sv
verification/wb_memory.sv
verification/cpu_chk.sv
verification/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation passed

SOURCES := $(shell grep -v '^+' files.f)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f files.f --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
